// File: flist.f
logic/adma_pkg.sv
logic/adma_desc_decode.sv
logic/adma_state_machine.sv
logic/adma_status.sv
logic/adma_top.sv
test/adma_tb_models.sv
test/adma_tb.sv

// File: logic/adma_desc_decode.sv
// fields hold their values until the next load_desc; only desc_valid is cleared by reset
module adma_desc_decode
   import adma_pkg::*;
(
   input  logic              CLK,
   input  logic              RESET,
   input  logic              load_desc,
   input  logic [DESC_W-1:0] desc_data,
   output logic [ADDR_W-1:0] desc_address,
   output logic [LEN_W-1:0]  desc_len,
   output adma_act_e         desc_act,
   output logic              desc_valid,
   output logic              desc_end,
   output logic              desc_int
);

   logic [LEN_FIELD_W-1:0] len_field;
   logic [1:0]             act_bits;
   logic [LEN_W-1:0]       len_wide;

   // raw field slices of the incoming word
   assign len_field = desc_data[LEN_MSB:LEN_LSB];
   assign act_bits  = {desc_data[ACT2_BIT], desc_data[ACT1_BIT]};

   // zero means 65536 bytes
   always_comb begin
      if (len_field == '0) begin
         len_wide = LEN_MAX;
      end else begin
         len_wide = {1'b0, len_field};
      end
   end

   // valid flag, cleared so a stale word never executes
   always_ff @(posedge CLK) begin
      if (RESET) begin
         desc_valid <= 1'b0;
      end else if (load_desc) begin
         desc_valid <= desc_data[VALID_BIT];
      end
   end

   // payload fields
   always_ff @(posedge CLK) begin
      if (load_desc) begin
         desc_address <= desc_data[ADDR_MSB:ADDR_LSB];
         desc_len     <= len_wide;
         desc_act     <= adma_act_e'(act_bits);
         desc_end     <= desc_data[END_BIT];
         desc_int     <= desc_data[INT_BIT];
      end
   end

endmodule

// File: logic/adma_pkg.sv
// ADMA2 descriptor layout is fixed at 96 bits, so every width below is constant, not tunable
package adma_pkg;

   // engine states, as in the ADMA2 state diagram
   typedef enum logic [1:0] {
      st_stop = 2'b00,
      st_fds  = 2'b01,
      st_cadr = 2'b10,
      st_tfr  = 2'b11
   } adma_state_e;

   // action encoding is {act2, act1}
   typedef enum logic [1:0] {
      act_nop  = 2'b00,
      act_rsv  = 2'b01,
      act_tran = 2'b10,
      act_link = 2'b11
   } adma_act_e;

   // widths
   localparam int ADDR_W      = 64;
   localparam int LEN_W       = 17;
   localparam int LEN_FIELD_W = 16;
   localparam int DESC_W      = 96;
   localparam int CNT_W       = 16;

   // field positions inside one descriptor
   localparam int ADDR_MSB  = 95;
   localparam int ADDR_LSB  = 32;
   localparam int LEN_MSB   = 31;
   localparam int LEN_LSB   = 16;
   localparam int ACT2_BIT  = 5;
   localparam int ACT1_BIT  = 4;
   localparam int INT_BIT   = 2;
   localparam int END_BIT   = 1;
   localparam int VALID_BIT = 0;

   // distance between consecutive descriptors in memory
   localparam logic [ADDR_W-1:0] DESC_BYTES = 64'd12;

   // a zero length field stands for a full 64 KiB transfer
   localparam logic [LEN_W-1:0] LEN_MAX = 17'h10000;

endpackage

// File: logic/adma_state_machine.sv
// stop_req is sampled only when a transfer completes; start and cont are ignored while busy
module adma_state_machine
   import adma_pkg::*;
(
   input  logic              CLK,
   input  logic              RESET,
   input  logic              start,
   input  logic              cont,
   input  logic              stop_req,
   input  logic [ADDR_W-1:0] base_addr,
   input  logic              desc_ack,
   output logic              desc_req,
   output logic [ADDR_W-1:0] desc_addr,
   output logic              load_desc,
   input  logic [ADDR_W-1:0] desc_address,
   input  logic [LEN_W-1:0]  desc_len,
   input  adma_act_e         desc_act,
   input  logic              desc_valid,
   input  logic              desc_end,
   output logic              xfer_start,
   output logic [ADDR_W-1:0] xfer_addr,
   output logic [LEN_W-1:0]  xfer_len,
   input  logic              xfer_done,
   output logic              busy,
   output logic              ev_done,
   output logic              ev_stopped,
   output logic              ev_error,
   output logic              ev_desc,
   output logic              ev_xfer_end,
   output logic              desc_count_clr
);

   adma_state_e       state;
   adma_state_e       state_nxt;
   logic [ADDR_W-1:0] ptr;
   logic [ADDR_W-1:0] xfer_addr_q;
   logic [LEN_W-1:0]  xfer_len_q;

   // fetch handshake, request held for the whole fetch state
   assign desc_req  = (state == st_fds);
   assign desc_addr = ptr;
   assign load_desc = desc_req && desc_ack;

   assign busy           = (state != st_stop);
   assign desc_count_clr = (state == st_stop) && start;

   // tran kicks the mover straight out of cadr
   assign xfer_start = (state == st_cadr) && desc_valid && (desc_act == act_tran);

   // decoded values shown in the start cycle, held copy afterwards
   assign xfer_addr = xfer_start ? desc_address : xfer_addr_q;
   assign xfer_len  = xfer_start ? desc_len : xfer_len_q;

   assign ev_xfer_end = (state == st_tfr) && xfer_done;

   // next state and event pulses
   always_comb begin
      state_nxt  = state;
      ev_done    = 1'b0;
      ev_stopped = 1'b0;
      ev_error   = 1'b0;
      ev_desc    = 1'b0;
      case (state)
         st_stop: begin
            if (start || cont) begin
               state_nxt = st_fds;
            end
         end
         st_fds: begin
            if (desc_ack) begin
               state_nxt = st_cadr;
            end
         end
         st_cadr: begin
            if (!desc_valid) begin
               // broken chain, give up
               state_nxt = st_stop;
               ev_error  = 1'b1;
            end else begin
               ev_desc = 1'b1;
               if (desc_act == act_tran) begin
                  state_nxt = st_tfr;
               end else if (desc_end) begin
                  state_nxt = st_stop;
                  ev_done   = 1'b1;
               end else begin
                  state_nxt = st_fds;
               end
            end
         end
         st_tfr: begin
            if (xfer_done) begin
               if (desc_end) begin
                  state_nxt = st_stop;
                  ev_done   = 1'b1;
               end else if (stop_req) begin
                  state_nxt  = st_stop;
                  ev_stopped = 1'b1;
               end else begin
                  state_nxt = st_fds;
               end
            end
         end
         default: begin
            state_nxt = st_stop;
         end
      endcase
   end

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state <= st_stop;
      end else begin
         state <= state_nxt;
      end
   end

   // descriptor pointer: base on start, follow link, else step
   always_ff @(posedge CLK) begin
      if (RESET) begin
         ptr <= '0;
      end else if (desc_count_clr) begin
         ptr <= base_addr;
      end else if ((state == st_cadr) && desc_valid) begin
         if (desc_act == act_link) begin
            ptr <= desc_address;
         end else begin
            ptr <= ptr + DESC_BYTES;
         end
      end
   end

   // transfer request copy for the mover
   always_ff @(posedge CLK) begin
      if (xfer_start) begin
         xfer_addr_q <= desc_address;
         xfer_len_q  <= desc_len;
      end
   end

endmodule

// File: logic/adma_status.sv
// every output lags its state machine event by one cycle; a new interrupt beats int_clear
module adma_status
   import adma_pkg::*;
(
   input  logic             CLK,
   input  logic             RESET,
   input  logic             ev_done,
   input  logic             ev_stopped,
   input  logic             ev_error,
   input  logic             ev_desc,
   input  logic             ev_xfer_end,
   input  logic             desc_count_clr,
   input  logic             desc_int,
   input  logic             int_clear,
   output logic             done,
   output logic             stopped,
   output logic             adma_error,
   output logic             int_flag,
   output logic [CNT_W-1:0] desc_count
);

   logic int_set;

   // transfer with int bit finished, or chain aborted
   assign int_set = (ev_xfer_end && desc_int) || ev_error;

   // one-cycle status pulses
   always_ff @(posedge CLK) begin
      if (RESET) begin
         done       <= 1'b0;
         stopped    <= 1'b0;
         adma_error <= 1'b0;
      end else begin
         done       <= ev_done;
         stopped    <= ev_stopped;
         adma_error <= ev_error;
      end
   end

   // sticky interrupt
   always_ff @(posedge CLK) begin
      if (RESET) begin
         int_flag <= 1'b0;
      end else if (int_set) begin
         int_flag <= 1'b1;
      end else if (int_clear) begin
         int_flag <= 1'b0;
      end
   end

   // descriptors consumed since the last start
   always_ff @(posedge CLK) begin
      if (RESET) begin
         desc_count <= '0;
      end else if (desc_count_clr) begin
         desc_count <= '0;
      end else if (ev_desc) begin
         // wraps after 65535, as a free-running counter
         desc_count <= desc_count + 1'b1;
      end
   end

endmodule

// File: logic/adma_top.sv
// descriptor memory and data mover sit outside; both may stall forever without a timeout
module adma_top
   import adma_pkg::*;
(
   input  logic              CLK,
   input  logic              RESET,
   // command side
   input  logic              start,
   input  logic [ADDR_W-1:0] base_addr,
   input  logic              cont,
   input  logic              stop_req,
   input  logic              int_clear,
   // descriptor memory
   output logic              desc_req,
   output logic [ADDR_W-1:0] desc_addr,
   input  logic              desc_ack,
   input  logic [DESC_W-1:0] desc_data,
   // data mover
   output logic              xfer_start,
   output logic [ADDR_W-1:0] xfer_addr,
   output logic [LEN_W-1:0]  xfer_len,
   input  logic              xfer_done,
   // status
   output logic              busy,
   output logic              done,
   output logic              stopped,
   output logic              adma_error,
   output logic              int_flag,
   output logic [CNT_W-1:0]  desc_count
);

   logic              load_desc;
   logic [ADDR_W-1:0] desc_address;
   logic [LEN_W-1:0]  desc_len;
   adma_act_e         desc_act;
   logic              desc_valid;
   logic              desc_end;
   logic              desc_int;
   logic              ev_done;
   logic              ev_stopped;
   logic              ev_error;
   logic              ev_desc;
   logic              ev_xfer_end;
   logic              desc_count_clr;

   adma_desc_decode u_decode (
      .CLK          (CLK),
      .RESET        (RESET),
      .load_desc    (load_desc),
      .desc_data    (desc_data),
      .desc_address (desc_address),
      .desc_len     (desc_len),
      .desc_act     (desc_act),
      .desc_valid   (desc_valid),
      .desc_end     (desc_end),
      .desc_int     (desc_int)
   );

   adma_state_machine u_fsm (
      .CLK            (CLK),
      .RESET          (RESET),
      .start          (start),
      .cont           (cont),
      .stop_req       (stop_req),
      .base_addr      (base_addr),
      .desc_ack       (desc_ack),
      .desc_req       (desc_req),
      .desc_addr      (desc_addr),
      .load_desc      (load_desc),
      .desc_address   (desc_address),
      .desc_len       (desc_len),
      .desc_act       (desc_act),
      .desc_valid     (desc_valid),
      .desc_end       (desc_end),
      .xfer_start     (xfer_start),
      .xfer_addr      (xfer_addr),
      .xfer_len       (xfer_len),
      .xfer_done      (xfer_done),
      .busy           (busy),
      .ev_done        (ev_done),
      .ev_stopped     (ev_stopped),
      .ev_error       (ev_error),
      .ev_desc        (ev_desc),
      .ev_xfer_end    (ev_xfer_end),
      .desc_count_clr (desc_count_clr)
   );

   adma_status u_status (
      .CLK            (CLK),
      .RESET          (RESET),
      .ev_done        (ev_done),
      .ev_stopped     (ev_stopped),
      .ev_error       (ev_error),
      .ev_desc        (ev_desc),
      .ev_xfer_end    (ev_xfer_end),
      .desc_count_clr (desc_count_clr),
      .desc_int       (desc_int),
      .int_clear      (int_clear),
      .done           (done),
      .stopped        (stopped),
      .adma_error     (adma_error),
      .int_flag       (int_flag),
      .desc_count     (desc_count)
   );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass line shows up
verilator --binary --timing --assert -Wno-fatal --top-module adma_tb -f flist.f -o adma_sim \
   && ./obj_dir/adma_sim | tee /dev/stderr | grep -qx "RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: test/adma_tb.sv
// tests run back to back from one reset; descriptor tables use disjoint address ranges
module adma_tb
   import adma_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   // descriptors over all tests, worst fetch and mover latency in cycles
   localparam int N_DESC    = 14;
   localparam int FETCH_MAX = 10;
   localparam int XFER_MAX  = 10;
   localparam int LIMIT     = N_DESC * (FETCH_MAX + XFER_MAX + 4) + 200;

   localparam logic [1:0] NOP  = 2'b00;
   localparam logic [1:0] TRAN = 2'b10;
   localparam logic [1:0] LINK = 2'b11;

   logic              CLK = 1'b0;
   logic              RESET;
   logic              start;
   logic              cont;
   logic              stop_req;
   logic              int_clear;
   logic [ADDR_W-1:0] base_addr;
   logic              desc_req;
   logic [ADDR_W-1:0] desc_addr;
   logic              desc_ack;
   logic [DESC_W-1:0] desc_data;
   logic              xfer_start;
   logic [ADDR_W-1:0] xfer_addr;
   logic [LEN_W-1:0]  xfer_len;
   logic              xfer_done;
   logic              busy;
   logic              done;
   logic              stopped;
   logic              adma_error;
   logic              int_flag;
   logic [CNT_W-1:0]  desc_count;

   int errors   = 0;
   int err_mark = 0;
   int tests    = 0;
   int failed   = 0;
   int cycles   = 0;
   int done_cnt = 0;
   int stop_cnt = 0;
   int err_cnt  = 0;
   int done0;
   int stop0;
   int err0;

   adma_top u_dut (.*);

   adma_tb_models u_models (.*);

   always #20 CLK = ~CLK;

   // pulse counters, read one cycle after a chain ends
   always @(posedge CLK) begin
      if (done) done_cnt <= done_cnt + 1;
      if (stopped) stop_cnt <= stop_cnt + 1;
      if (adma_error) err_cnt <= err_cnt + 1;
   end

   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycles == LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // status pulses last one cycle, and only once the engine is idle
   assert property (@(posedge CLK) disable iff (RESET)
      (done || stopped || adma_error) |=> !(done || stopped || adma_error))
      else begin
         errors++;
         $display("status pulse held longer than one cycle at %0t ns", $time);
      end
   assert property (@(posedge CLK) disable iff (RESET)
      (done || stopped || adma_error) |-> !busy)
      else begin
         errors++;
         $display("engine still busy at a status pulse at %0t ns", $time);
      end
   assert property (@(posedge CLK) disable iff (RESET) xfer_start |-> busy && !desc_req)
      else begin
         errors++;
         $display("transfer started outside a decode cycle at %0t ns", $time);
      end
   // int_flag rises only after a finished transfer or an error, falls only on int_clear
   assert property (@(posedge CLK) disable iff (RESET)
      $rose(int_flag) |-> $past(xfer_done) || adma_error)
      else begin
         errors++;
         $display("int_flag rose without a transfer end at %0t ns", $time);
      end
   assert property (@(posedge CLK) disable iff (RESET) $fell(int_flag) |-> $past(int_clear))
      else begin
         errors++;
         $display("int_flag fell without int_clear at %0t ns", $time);
      end

   function automatic logic [DESC_W-1:0] make_desc(input logic [63:0] addr,
      input logic [15:0] len, input logic [1:0] act, input logic irq, input logic last,
      input logic valid);
      return {addr, len, 10'd0, act, 1'b0, irq, last, valid};
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got == exp) else begin
         errors++;
         $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_xfer(input int idx, input logic [63:0] addr, input logic [16:0] len);
      if (idx >= u_models.xfer_addr_log.size()) begin
         errors++;
         $display("transfer %0d never reached the data mover", idx);
      end else begin
         check_val($sformatf("xfer_addr[%0d]", idx), u_models.xfer_addr_log[idx], addr);
         check_val($sformatf("xfer_len[%0d]", idx), 64'(u_models.xfer_len_log[idx]), 64'(len));
      end
   endtask

   task automatic check_fetch(input int idx, input logic [63:0] addr);
      if (idx >= u_models.fetch_log.size()) begin
         errors++;
         $display("fetch %0d never happened", idx);
      end else begin
         check_val($sformatf("desc_addr[%0d]", idx), u_models.fetch_log[idx], addr);
      end
   endtask

   task automatic begin_test();
      err_mark = errors;
      done0 = done_cnt;
      stop0 = stop_cnt;
      err0  = err_cnt;
      u_models.fetch_log.delete();
      u_models.xfer_addr_log.delete();
      u_models.xfer_len_log.delete();
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: failed with %0d errors", name, errors - err_mark);
      end
   endtask

   // start from base, or resume with cont, then wait for the chain to end
   task automatic launch(input logic [63:0] base, input logic resume);
      @(posedge CLK);
      if (resume) begin
         cont <= 1'b1;
      end else begin
         start     <= 1'b1;
         base_addr <= base;
      end
      @(posedge CLK);
      start <= 1'b0;
      cont  <= 1'b0;
      do begin
         @(posedge CLK);
      end while (!(done || stopped || adma_error));
      @(posedge CLK);
   endtask

   task automatic pulse_int_clear();
      @(posedge CLK);
      int_clear <= 1'b1;
      @(posedge CLK);
      int_clear <= 1'b0;
      @(posedge CLK);
   endtask

   task automatic tran_chain_test();
      begin_test();
      u_models.desc_table[64'h1000] = make_desc(64'h8000_0000, 16'h0200, TRAN, 0, 0, 1);
      u_models.desc_table[64'h100C] = make_desc(64'h8000_1000, 16'h0040, TRAN, 0, 0, 1);
      u_models.desc_table[64'h1018] = make_desc(64'h8000_2000, 16'h1000, TRAN, 0, 1, 1);
      launch(64'h1000, 1'b0);
      check_val("transfer count", 64'(u_models.xfer_addr_log.size()), 64'd3);
      check_xfer(0, 64'h8000_0000, 17'h00200);
      check_xfer(1, 64'h8000_1000, 17'h00040);
      check_xfer(2, 64'h8000_2000, 17'h01000);
      check_val("done pulses", 64'(done_cnt - done0), 64'd1);
      check_val("desc_count", 64'(desc_count), 64'd3);
      check_val("busy", 64'(busy), 64'd0);
      end_test("tran chain");
   endtask

   task automatic link_skip_test();
      begin_test();
      u_models.desc_table[64'h2000] = make_desc(64'h3000, 16'h0000, LINK, 0, 0, 1);
      u_models.desc_table[64'h3000] = make_desc(64'h0, 16'h0000, NOP, 0, 0, 1);
      u_models.desc_table[64'h300C] = make_desc(64'hABCD_0000, 16'h0080, TRAN, 0, 1, 1);
      launch(64'h2000, 1'b0);
      check_val("fetch count", 64'(u_models.fetch_log.size()), 64'd3);
      check_fetch(1, 64'h3000);
      check_fetch(2, 64'h300C);
      check_val("transfer count", 64'(u_models.xfer_addr_log.size()), 64'd1);
      check_xfer(0, 64'hABCD_0000, 17'h00080);
      check_val("done pulses", 64'(done_cnt - done0), 64'd1);
      // a link with end set ends the chain without fetching its target
      u_models.desc_table[64'h2100] = make_desc(64'h3000, 16'h0000, LINK, 0, 1, 1);
      launch(64'h2100, 1'b0);
      check_val("fetch count", 64'(u_models.fetch_log.size()), 64'd4);
      check_val("transfer count", 64'(u_models.xfer_addr_log.size()), 64'd1);
      check_val("done pulses", 64'(done_cnt - done0), 64'd2);
      end_test("link and skip");
   endtask

   task automatic zero_length_test();
      begin_test();
      u_models.desc_table[64'h4000] = make_desc(64'h9000_0000, 16'h0000, TRAN, 0, 1, 1);
      launch(64'h4000, 1'b0);
      check_xfer(0, 64'h9000_0000, 17'h10000);
      end_test("length zero");
   endtask

   task automatic interrupt_test();
      begin_test();
      u_models.desc_table[64'h5000] = make_desc(64'hA000_0000, 16'h0010, TRAN, 1, 1, 1);
      u_models.desc_table[64'h5100] = make_desc(64'hA000_1000, 16'h0010, TRAN, 0, 1, 1);
      launch(64'h5000, 1'b0);
      check_val("int_flag", 64'(int_flag), 64'd1);
      repeat (3) @(posedge CLK);
      check_val("int_flag", 64'(int_flag), 64'd1);
      pulse_int_clear();
      check_val("int_flag", 64'(int_flag), 64'd0);
      launch(64'h5100, 1'b0);
      check_val("int_flag", 64'(int_flag), 64'd0);
      end_test("interrupt");
   endtask

   task automatic invalid_test();
      begin_test();
      u_models.desc_table[64'h6000] = make_desc(64'hB000_0000, 16'h0020, TRAN, 0, 1, 0);
      launch(64'h6000, 1'b0);
      check_val("adma_error pulses", 64'(err_cnt - err0), 64'd1);
      check_val("done pulses", 64'(done_cnt - done0), 64'd0);
      check_val("transfer count", 64'(u_models.xfer_addr_log.size()), 64'd0);
      check_val("busy", 64'(busy), 64'd0);
      check_val("int_flag", 64'(int_flag), 64'd1);
      pulse_int_clear();
      end_test("invalid descriptor");
   endtask

   task automatic stop_continue_test();
      begin_test();
      u_models.desc_table[64'h7000] = make_desc(64'hC000_0000, 16'h0100, TRAN, 0, 0, 1);
      u_models.desc_table[64'h700C] = make_desc(64'hC000_1000, 16'h0200, TRAN, 0, 0, 1);
      u_models.desc_table[64'h7018] = make_desc(64'hC000_2000, 16'h0300, TRAN, 0, 1, 1);
      @(posedge CLK);
      stop_req <= 1'b1;
      launch(64'h7000, 1'b0);
      check_val("stopped pulses", 64'(stop_cnt - stop0), 64'd1);
      check_val("transfer count", 64'(u_models.xfer_addr_log.size()), 64'd1);
      // engine must stay parked while stop_req is held
      repeat (8) @(posedge CLK);
      check_val("fetch count", 64'(u_models.fetch_log.size()), 64'd1);
      stop_req <= 1'b0;
      launch(64'h0, 1'b1);
      check_val("fetch count", 64'(u_models.fetch_log.size()), 64'd3);
      check_fetch(1, 64'h7000 + 64'd12);
      check_xfer(2, 64'hC000_2000, 17'h00300);
      check_val("done pulses", 64'(done_cnt - done0), 64'd1);
      check_val("desc_count", 64'(desc_count), 64'd3);
      end_test("stop and continue");
   endtask

   initial begin
      RESET     = 1'b1;
      start     = 1'b0;
      cont      = 1'b0;
      stop_req  = 1'b0;
      int_clear = 1'b0;
      base_addr = '0;
      repeat (4) @(posedge CLK);
      RESET <= 1'b0;
      tran_chain_test();
      link_skip_test();
      zero_length_test();
      interrupt_test();
      invalid_test();
      stop_continue_test();
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: test/adma_tb_models.sv
// memory answers unknown addresses with an all-zero (invalid) word; ack and done delays are 0..7
module adma_tb_models
   import adma_pkg::*;
(
   input  logic              CLK,
   input  logic              RESET,
   input  logic              desc_req,
   input  logic [ADDR_W-1:0] desc_addr,
   output logic              desc_ack,
   output logic [DESC_W-1:0] desc_data,
   input  logic              xfer_start,
   input  logic [ADDR_W-1:0] xfer_addr,
   input  logic [LEN_W-1:0]  xfer_len,
   output logic              xfer_done
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [DESC_W-1:0] desc_table [logic [ADDR_W-1:0]];
   logic [ADDR_W-1:0] fetch_log [$];
   logic [ADDR_W-1:0] xfer_addr_log [$];
   logic [LEN_W-1:0]  xfer_len_log [$];
   logic [15:0]       lfsr = 16'd23200;
   logic              fetch_busy;
   logic              mover_busy;
   logic [2:0]        fetch_wait;
   logic [2:0]        mover_wait;

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one step per delay bit
   function automatic logic [2:0] draw_delay();
      logic [2:0] d;
      d = 3'd0;
      for (int i = 0; i < 3; i++) begin
         lfsr = lfsr_next(lfsr);
         d = {d[1:0], lfsr[0]};
      end
      return d;
   endfunction

   initial begin
      desc_ack  = 1'b0;
      desc_data = '0;
      xfer_done = 1'b0;
   end

   // descriptor memory, one ack per request after a random wait
   always @(posedge CLK) begin
      desc_ack <= 1'b0;
      if (RESET) begin
         fetch_busy <= 1'b0;
      end else if (desc_req && !desc_ack) begin
         if (!fetch_busy) begin
            fetch_busy <= 1'b1;
            fetch_wait <= draw_delay();
         end else if (fetch_wait == 3'd0) begin
            fetch_busy <= 1'b0;
            desc_ack   <= 1'b1;
            desc_data  <= desc_table.exists(desc_addr) ? desc_table[desc_addr] : '0;
            fetch_log.push_back(desc_addr);
         end else begin
            fetch_wait <= fetch_wait - 3'd1;
         end
      end
   end

   // data mover, logs each request and pulses done later
   always @(posedge CLK) begin
      xfer_done <= 1'b0;
      if (RESET) begin
         mover_busy <= 1'b0;
      end else if (xfer_start) begin
         mover_busy <= 1'b1;
         mover_wait <= draw_delay();
         xfer_addr_log.push_back(xfer_addr);
         xfer_len_log.push_back(xfer_len);
      end else if (mover_busy) begin
         if (mover_wait == 3'd0) begin
            mover_busy <= 1'b0;
            xfer_done  <= 1'b1;
         end else begin
            mover_wait <= mover_wait - 3'd1;
         end
      end
   end

endmodule
